// File: files.f
design/dcache_pkg.sv
design/ldst_align.sv
design/bank_dispatch.sv
design/dcache_bank.sv
design/resp_merge.sv
design/dcache_top.sv
tests/dcache_asserts.sv
tests/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= dcache_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int num_banks  = 4;
    localparam int lines      = 16;
    localparam int period     = 20;
    localparam int n_random   = 2000;
    localparam int n_directed = 80;
    localparam int worst_lat  = 8; // issue, slowest refill and response.

    typedef struct packed {
        logic        check_load;
        logic        check_mem;
        logic        io;
        logic [29:0] waddr;
        logic [31:0] exp;
    } expect_t;

    logic                  clk, rst, req_valid, resp_valid, mem_req_valid, mem_ack;
    dcache_pkg::cpu_req_t  req;
    dcache_pkg::cpu_resp_t resp;
    dcache_pkg::mem_req_t  mem_req;
    logic [31:0]           mem_rdata;
    logic [31:0]           mem_words [logic [29:0]]; // sparse backing store.
    logic [31:0]           io_count = 32'h7fff_fffe;
    logic [31:0]           io_write_word = '0; // last I/O store, unwritten lanes zero.
    expect_t               exp_q [$];
    int                    done_count = 0;
    int                    issued = 0;
    int                    mem_req_count = 0;
    int                    last_lat, last_mem_reqs;

    dcache_top #(
        .num_banks (num_banks),
        .lines     (lines)
    ) uut (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // untouched words hold a pattern built from the whole word address.
    function automatic logic [31:0] read_word(input logic [29:0] waddr);
        if (mem_words.exists(waddr)) begin
            return mem_words[waddr];
        end
        return {waddr[13:0], waddr[29:12]} ^ 32'h6b3d_a5c1;
    endfunction

    function automatic logic [31:0] ref_load(input logic [31:0] word,
                                             input dcache_pkg::ldst_op_e op,
                                             input logic [1:0] off);
        logic [31:0] by_byte, by_half;
        by_byte = word >> {off, 3'b000};
        by_half = word >> {off[1], 4'b0000}; // halves ignore bit 0.
        case (op)
            dcache_pkg::lh:  return {{16{by_half[15]}}, by_half[15:0]};
            dcache_pkg::lhu: return {16'h0000, by_half[15:0]};
            dcache_pkg::lb:  return {{24{by_byte[7]}}, by_byte[7:0]};
            dcache_pkg::lbu: return {24'h000000, by_byte[7:0]};
            default:         return word;
        endcase
    endfunction

    function automatic logic [31:0] ref_store(input logic [31:0] old,
                                              input dcache_pkg::ldst_op_e op,
                                              input logic [1:0] off,
                                              input logic [31:0] wdata);
        logic [31:0] res;
        res = old;
        case (op)
            dcache_pkg::sw: res = wdata;
            dcache_pkg::sh: res[{off[1], 4'b0000} +: 16] = wdata[15:0];
            dcache_pkg::sb: res[{off, 3'b000} +: 8] = wdata[7:0];
            default:        res = old;
        endcase
        return res;
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // called 1 ns after a rising edge, returns the same way once resp_valid was seen.
    task automatic run_access(input dcache_pkg::ldst_op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata);
        expect_t e;
        int      reqs_before;
        logic    io;
        io           = (addr[31:16] == 16'hffff);
        e.check_load = !dcache_pkg::is_store(op);
        e.check_mem  = dcache_pkg::is_store(op);
        e.io         = io;
        e.waddr      = addr[31:2];
        if (e.check_load) begin
            e.exp = ref_load(io ? io_count : read_word(addr[31:2]), op, addr[1:0]);
        end else begin
            e.exp = ref_store(io ? 32'h0 : read_word(addr[31:2]), op, addr[1:0], wdata);
        end
        exp_q.push_back(e);
        issued      = issued + 1;
        reqs_before = mem_req_count;
        req_valid   = 1'b1;
        req.addr    = addr;
        req.op      = op;
        req.wdata   = wdata;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        last_lat  = 0;
        while (done_count != issued) begin
            @(posedge clk);
            #1;
            last_lat = last_lat + 1;
        end
        last_mem_reqs = mem_req_count - reqs_before;
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    initial begin : memory_model
        dcache_pkg::mem_req_t hold;
        logic [31:0]          delay_rng, word;
        delay_rng = xorshift(32'h5a7c);
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            if (!rst && mem_req_valid) begin
                hold          = mem_req;
                mem_req_count = mem_req_count + 1;
                delay_rng     = xorshift(delay_rng);
                repeat (delay_rng[1:0]) @(posedge clk); // 1 to 4 cycles to the ack.
                #1;
                if (hold.addr[31:16] == 16'hffff) begin
                    mem_rdata = io_count;
                    if (hold.we) begin
                        word = '0;
                        for (int b = 0; b < 4; b++) begin
                            if (hold.be[b]) begin
                                word[8*b +: 8] = hold.wdata[8*b +: 8];
                            end
                        end
                        io_write_word = word;
                    end else begin
                        io_count = io_count + 1;
                    end
                end else begin
                    word = read_word(hold.addr[31:2]);
                    for (int b = 0; b < 4; b++) begin
                        if (hold.we && hold.be[b]) begin
                            word[8*b +: 8] = hold.wdata[8*b +: 8];
                        end
                    end
                    mem_words[hold.addr[31:2]] = word;
                    mem_rdata = word;
                end
                mem_ack = 1'b1;
                @(posedge clk);
                #1;
                mem_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin : compare
        expect_t e;
        if (!rst && resp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("a response arrived with no request outstanding");
                abort_run();
            end else begin
                e = exp_q.pop_front();
                if (e.check_load) begin
                    check_value("load data", resp.rdata, e.exp);
                end
                if (e.check_mem) begin
                    check_value("memory word after store",
                                e.io ? io_write_word : read_word(e.waddr), e.exp);
                end
                done_count = done_count + 1;
            end
        end
    end

    initial begin : watchdog
        #(((n_random + n_directed) * worst_lat + 200) * period);
        $display("the run did not finish in time, the DUT seems to be stuck");
        abort_run();
    end

    initial begin : stimulus
        logic [31:0]          stim_rng, r, addr;
        dcache_pkg::ldst_op_e op;
        stim_rng  = 32'h5a7c;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (10) begin
            @(posedge clk);
            check_value("resp_valid while idle", 32'(resp_valid), 32'd0);
            check_value("mem_req_valid while idle", 32'(mem_req_valid), 32'd0);
        end
        #1;
        run_access(dcache_pkg::sw, 32'h0000_1040, 32'h8180_7f01); // negative upper half.
        for (int k = 0; k < 4; k++) begin
            run_access(dcache_pkg::lb, 32'h0000_1040 + k, '0);
            run_access(dcache_pkg::lbu, 32'h0000_1040 + k, '0);
        end
        for (int k = 0; k < 4; k += 2) begin
            run_access(dcache_pkg::lh, 32'h0000_1040 + k, '0);
            run_access(dcache_pkg::lhu, 32'h0000_1040 + k, '0);
        end
        run_access(dcache_pkg::sh, 32'h0000_1042, 32'h1234_fe55);
        run_access(dcache_pkg::sb, 32'h0000_1041, 32'h0000_00c3);
        run_access(dcache_pkg::lw, 32'h0000_1040, '0);
        run_access(dcache_pkg::lh, 32'h0000_1042, '0);
        run_access(dcache_pkg::lw, 32'h0000_2100, '0);
        check_value("miss memory requests", 32'(last_mem_reqs), 32'd1);
        run_access(dcache_pkg::lw, 32'h0000_2100, '0);
        check_value("hit latency", 32'(last_lat), 32'd1);
        check_value("hit memory requests", 32'(last_mem_reqs), 32'd0);
        run_access(dcache_pkg::lw, 32'h0000_2100 + num_banks * lines * 4, '0);
        check_value("conflict memory requests", 32'(last_mem_reqs), 32'd1);
        run_access(dcache_pkg::lw, 32'h0000_2100, '0);
        check_value("refill after eviction", 32'(last_mem_reqs), 32'd1);
        run_access(dcache_pkg::sb, 32'h0000_2103, 32'h0000_0096);
        check_value("write-through requests", 32'(last_mem_reqs), 32'd1);
        run_access(dcache_pkg::lw, 32'h0000_2100, '0);
        check_value("hit latency after store", 32'(last_lat), 32'd1);
        check_value("hit after store requests", 32'(last_mem_reqs), 32'd0);
        repeat (4) begin
            run_access(dcache_pkg::lw, 32'hffff_0010, '0);
            check_value("I/O load requests", 32'(last_mem_reqs), 32'd1);
        end
        run_access(dcache_pkg::lb, 32'hffff_0013, '0);
        for (int n = 0; n < n_random; n++) begin
            stim_rng = xorshift(stim_rng);
            r        = stim_rng;
            op       = dcache_pkg::ldst_op_e'({1'b0, r[2:0]});
            // one access in sixteen goes to the I/O region.
            addr     = (r[7:4] == 4'd0) ? {16'hffff, r[31:16]}
                                        : 32'h0000_1000 + {22'd0, r[17:8]};
            stim_rng = xorshift(stim_rng);
            run_access(op, addr, stim_rng);
        end
        if (uut.u_asserts.fail_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures were reported", uut.u_asserts.fail_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: tests/dcache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_asserts (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic resp_valid,
    input logic mem_req_valid,
    input logic mem_ack
);

    logic pending, mem_out, seen_req;
    int   fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= 1'b0;
            mem_out  <= 1'b0;
            seen_req <= 1'b0;
        end else begin
            if (req_valid) begin
                pending  <= 1'b1;
                seen_req <= 1'b1;
            end else if (resp_valid) begin
                pending <= 1'b0;
            end
            if (mem_req_valid) begin
                mem_out <= 1'b1;
            end else if (mem_ack) begin
                mem_out <= 1'b0;
            end
        end
    end

    a_req_idle: assert property (@(posedge clk) disable iff (rst) req_valid |-> !pending)
        else begin
            fail_count++;
            $error("request issued while an access is pending");
        end

    a_ack_owned: assert property (@(posedge clk) disable iff (rst) mem_ack |-> mem_out)
        else begin
            fail_count++;
            $error("mem_ack without an outstanding memory request");
        end

    // the pending flag drops with the response, so a second one fails.
    a_one_resp: assert property (@(posedge clk) disable iff (rst) resp_valid |-> pending)
        else begin
            fail_count++;
            $error("resp_valid without a matching request");
        end

    a_quiet_start: assert property (@(posedge clk) disable iff (rst)
        !seen_req |-> (!resp_valid && !mem_req_valid))
        else begin
            fail_count++;
            $error("activity before the first request");
        end

endmodule

bind dcache_top dcache_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .resp_valid    (resp_valid),
    .mem_req_valid (mem_req_valid),
    .mem_ack       (mem_ack)
);

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int num_banks = dcache_pkg::num_banks_default,
    parameter int lines     = dcache_pkg::lines_default
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  dcache_pkg::cpu_req_t  req,
    output logic                  resp_valid,
    output dcache_pkg::cpu_resp_t resp,
    output logic                  mem_req_valid,
    output dcache_pkg::mem_req_t  mem_req,
    input  logic                  mem_ack,
    input  logic [31:0]           mem_rdata
);

    logic [num_banks-1:0] bank_sel;
    logic [num_banks-1:0] bank_mem_valid;
    logic [num_banks-1:0] bank_done;
    logic [num_banks-1:0] bank_ack;
    logic                 io_valid;
    dcache_pkg::mem_req_t bank_mem_req [num_banks];
    logic [31:0]          bank_word [num_banks];

    bank_dispatch #(
        .num_banks (num_banks)
    ) u_dispatch (
        .req_valid (req_valid),
        .req       (req),
        .bank_sel  (bank_sel),
        .io_valid  (io_valid)
    );

    for (genvar i = 0; i < num_banks; i++) begin : g_bank
        dcache_bank #(
            .num_banks (num_banks),
            .lines     (lines)
        ) u_bank (
            .clk       (clk),
            .rst       (rst),
            .sel       (bank_sel[i]),
            .req       (req),
            .mem_valid (bank_mem_valid[i]),
            .mem_req   (bank_mem_req[i]),
            .mem_ack   (bank_ack[i]),
            .mem_rdata (mem_rdata),
            .done      (bank_done[i]),
            .word      (bank_word[i])
        );
    end

    resp_merge #(
        .num_banks (num_banks)
    ) u_merge (
        .clk            (clk),
        .rst            (rst),
        .bank_sel       (bank_sel),
        .io_valid       (io_valid),
        .req            (req),
        .bank_mem_valid (bank_mem_valid),
        .bank_mem_req   (bank_mem_req),
        .bank_done      (bank_done),
        .bank_word      (bank_word),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_ack        (mem_ack),
        .mem_rdata      (mem_rdata),
        .bank_ack       (bank_ack),
        .resp_valid     (resp_valid),
        .resp           (resp)
    );

endmodule

`default_nettype wire

// File: design/resp_merge.sv
`timescale 1ns/1ps
`default_nettype none

module resp_merge #(
    parameter int num_banks = dcache_pkg::num_banks_default
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [num_banks-1:0]  bank_sel,
    input  logic                  io_valid,
    input  dcache_pkg::cpu_req_t  req,
    input  logic [num_banks-1:0]  bank_mem_valid,
    input  dcache_pkg::mem_req_t  bank_mem_req [num_banks],
    input  logic [num_banks-1:0]  bank_done,
    input  logic [31:0]           bank_word [num_banks],
    output logic                  mem_req_valid,
    output dcache_pkg::mem_req_t  mem_req,
    input  logic                  mem_ack,
    input  logic [31:0]           mem_rdata,
    output logic [num_banks-1:0]  bank_ack,
    output logic                  resp_valid,
    output dcache_pkg::cpu_resp_t resp
);

    localparam int bank_bits = $clog2(num_banks);

    logic [bank_bits-1:0] owner_q, sel_idx;
    logic                 io_own_q, io_mem_valid_q, io_done_q;
    dcache_pkg::mem_req_t io_req_q;
    dcache_pkg::ldst_op_e op_q, align_op;
    logic [1:0]           off_q, align_off;
    logic [31:0]          io_word_q, final_word, store_word, load_data;
    logic [3:0]           store_be;

    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < num_banks; i++) begin
            if (bank_sel[i]) begin
                sel_idx = bank_bits'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q        <= '0;
            io_own_q       <= 1'b0;
            io_mem_valid_q <= 1'b0;
            io_done_q      <= 1'b0;
        end else begin
            io_mem_valid_q <= io_valid;
            io_done_q      <= mem_ack && io_own_q;
            if (io_valid) begin
                io_own_q <= 1'b1;
            end else if (|bank_sel) begin
                io_own_q <= 1'b0;
                owner_q  <= sel_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (io_valid || |bank_sel) begin
            op_q  <= req.op;
            off_q <= req.addr[1:0];
        end
        if (io_valid) begin
            io_req_q.addr  <= {req.addr[31:2], 2'b00};
            io_req_q.we    <= dcache_pkg::is_store(req.op);
            io_req_q.be    <= dcache_pkg::is_store(req.op) ? store_be : 4'b1111;
            io_req_q.wdata <= store_word;
        end
        if (mem_ack && io_own_q) begin
            io_word_q <= mem_rdata;
        end
    end

    // the new I/O request borrows the aligner, a response never shares its cycle.
    assign align_op  = io_valid ? req.op : op_q;
    assign align_off = io_valid ? req.addr[1:0] : off_q;

    ldst_align u_align (
        .op         (align_op),
        .byte_off   (align_off),
        .word_in    (final_word),
        .store_data (req.wdata),
        .load_data  (load_data),
        .store_word (store_word),
        .store_be   (store_be)
    );

    assign mem_req_valid = io_own_q ? io_mem_valid_q : bank_mem_valid[owner_q];
    assign mem_req       = io_own_q ? io_req_q : bank_mem_req[owner_q];
    assign bank_ack      = (mem_ack && !io_own_q) ? (num_banks'(1) << owner_q) : '0;

    assign final_word = io_done_q ? io_word_q : bank_word[owner_q];
    assign resp_valid = io_done_q || (|bank_done);
    assign resp.rdata = load_data;

endmodule

`default_nettype wire

// File: design/dcache_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_bank #(
    parameter int num_banks = dcache_pkg::num_banks_default,
    parameter int lines     = dcache_pkg::lines_default
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sel,
    input  dcache_pkg::cpu_req_t req,
    output logic                 mem_valid,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_ack,
    input  logic [31:0]          mem_rdata,
    output logic                 done,
    output logic [31:0]          word
);

    localparam int bank_bits  = $clog2(num_banks);
    localparam int index_bits = $clog2(lines);
    localparam int tag_bits   = 30 - bank_bits - index_bits;

    typedef enum logic [1:0] {
        st_idle,
        st_resp,
        st_wait
    } state_t;

    state_t state;

    logic [tag_bits-1:0]   tag_mem  [lines];
    logic [31:0]           data_mem [lines];
    logic [lines-1:0]      valid;

    logic [index_bits-1:0] idx, idx_q;
    logic [tag_bits-1:0]   tag, tag_q;
    logic                  hit, hit_q, store, store_q, accept;
    logic [31:0]           line_word, store_word, lane_mask, merged, merged_q, word_q;
    logic [3:0]            store_be;

    assign idx       = req.addr[2 + bank_bits +: index_bits];
    assign tag       = req.addr[31 -: tag_bits];
    assign line_word = data_mem[idx];
    assign hit       = valid[idx] && (tag_mem[idx] == tag);
    assign store     = dcache_pkg::is_store(req.op);
    assign accept    = sel && (state == st_idle);

    ldst_align u_align (
        .op         (req.op),
        .byte_off   (req.addr[1:0]),
        .word_in    (line_word),
        .store_data (req.wdata),
        .load_data  (),
        .store_word (store_word),
        .store_be   (store_be)
    );

    assign lane_mask = {{8{store_be[3]}}, {8{store_be[2]}}, {8{store_be[1]}}, {8{store_be[0]}}};
    assign merged    = (line_word & ~lane_mask) | (store_word & lane_mask);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            mem_valid <= 1'b0;
            valid     <= '0;
        end else begin
            mem_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (hit && !store) begin
                            state <= st_resp;
                        end else begin
                            state     <= st_wait; // miss or write-through.
                            mem_valid <= 1'b1;
                        end
                    end
                end
                st_resp: state <= st_idle;
                st_wait: begin
                    if (mem_ack) begin
                        state <= st_resp;
                        if (!store_q) begin
                            valid[idx_q] <= 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q         <= idx;
            tag_q         <= tag;
            hit_q         <= hit;
            store_q       <= store;
            merged_q      <= merged;
            word_q        <= line_word;
            mem_req.addr  <= {req.addr[31:2], 2'b00};
            mem_req.we    <= store;
            mem_req.be    <= store ? store_be : 4'b1111;
            mem_req.wdata <= store_word;
        end
        if (state == st_wait && mem_ack) begin
            word_q <= mem_rdata;
            if (!store_q) begin
                tag_mem[idx_q]  <= tag_q; // refill.
                data_mem[idx_q] <= mem_rdata;
            end else if (hit_q) begin
                data_mem[idx_q] <= merged_q;
            end
        end
    end

    assign done = (state == st_resp);
    assign word = word_q;

endmodule

`default_nettype wire

// File: design/bank_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module bank_dispatch #(
    parameter int num_banks = dcache_pkg::num_banks_default
) (
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    output logic [num_banks-1:0] bank_sel,
    output logic                 io_valid
);

    localparam int bank_bits = $clog2(num_banks);

    logic                 io_hit;
    logic [bank_bits-1:0] bank_idx;

    assign io_hit   = dcache_pkg::is_io(req.addr);
    assign bank_idx = req.addr[2 +: bank_bits]; // lowest word-address bits.

    // I/O never reaches a bank.
    assign io_valid = req_valid && io_hit;

    always_comb begin
        bank_sel = '0;
        if (req_valid && !io_hit) begin
            bank_sel[bank_idx] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/ldst_align.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_align (
    input  dcache_pkg::ldst_op_e op,
    input  logic [1:0]           byte_off,
    input  logic [31:0]          word_in,
    input  logic [31:0]          store_data,
    output logic [31:0]          load_data,
    output logic [31:0]          store_word,
    output logic [3:0]           store_be
);

    logic [15:0] lane_half;
    logic [7:0]  lane_byte;
    logic [4:0]  shift;

    assign shift = {byte_off, 3'b000};

    // load path.
    always_comb begin
        lane_half = byte_off[1] ? word_in[31:16] : word_in[15:0];
        lane_byte = 8'(word_in >> shift);
        case (op)
            dcache_pkg::lh: begin
                load_data = {{16{lane_half[15]}}, lane_half};
            end
            dcache_pkg::lhu: begin
                load_data = {16'h0000, lane_half};
            end
            dcache_pkg::lb: begin
                load_data = {{24{lane_byte[7]}}, lane_byte};
            end
            dcache_pkg::lbu: begin
                load_data = {24'h000000, lane_byte};
            end
            default: begin
                load_data = word_in; // lw, stores pass the word.
            end
        endcase
    end

    // store path, data moved into its lanes.
    always_comb begin
        case (op)
            dcache_pkg::sw: begin
                store_word = store_data;
                store_be   = 4'b1111;
            end
            dcache_pkg::sh: begin
                store_word = byte_off[1] ? {store_data[15:0], 16'h0000}
                                         : {16'h0000, store_data[15:0]};
                store_be   = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            dcache_pkg::sb: begin
                store_word = {24'h000000, store_data[7:0]} << shift;
                store_be   = 4'b0001 << byte_off;
            end
            default: begin
                store_word = '0;
                store_be   = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int num_banks_default = 4;
    localparam int lines_default = 256;

    // upper address half that selects the I/O region.
    localparam logic [15:0] io_prefix = 16'hffff;

    typedef enum logic [3:0] {
        lw  = 4'd0,
        lh  = 4'd1,
        lhu = 4'd2,
        lb  = 4'd3,
        lbu = 4'd4,
        sw  = 4'd5,
        sh  = 4'd6,
        sb  = 4'd7
    } ldst_op_e;

    typedef struct packed {
        logic [31:0] addr;
        ldst_op_e    op;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata; // aligned and extended.
    } cpu_resp_t;

    typedef struct packed {
        logic [31:0] addr;  // word aligned.
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
    } mem_req_t;

    function automatic logic is_store(input ldst_op_e op);
        return op inside {sw, sh, sb};
    endfunction

    function automatic logic is_io(input logic [31:0] addr);
        return addr[31:16] == io_prefix;
    endfunction

endpackage

`default_nettype wire
